// File: common/dll_pkg.sv
// shared dll code widths, search states and the split gray mapping, imported by the rtl blocks
package dll_pkg;

  // ----------------------------------------------------------
  // code and value widths
  // ----------------------------------------------------------
  typedef logic [9:0]  dll_code_t;   // programmed or reference code, binary or gray
  typedef logic [12:0] dll_value_t;  // internal or filtered value, upper 10 bits are the code
  typedef logic [14:0] dll_track_t;  // internal value joined with its 2 bit filter
  typedef logic [4:0]  dll_step_t;   // one-hot step, bit 0 fine, bits 1..4 coarse

  // bit 3 is the direction (1 = down), bit 2 set above level 0
  typedef enum logic [3:0] {
    UP_S0 = 4'b0000,
    UP_S1 = 4'b0100,
    UP_S2 = 4'b0101,
    UP_S3 = 4'b0110,
    UP_S4 = 4'b0111,
    DN_S0 = 4'b1000,
    DN_S1 = 4'b1100,
    DN_S2 = 4'b1101,
    DN_S3 = 4'b1110,
    DN_S4 = 4'b1111
  } dll_state_e;

  localparam int DLL_FRAME_CYCLES  = 16;  // cycles per gate frame
  localparam int LOCK_COUNT_TARGET = 8;   // lock detections before lock is flagged

  // coarse field [9:3] and fine field [2:0] are gray coded on their own
  function automatic dll_code_t to_split_gray(input dll_code_t bin);
    logic [6:0] coarse;
    logic [2:0] fine;
    coarse = bin[9:3];
    fine   = bin[2:0];
    return {coarse ^ (coarse >> 1), fine ^ (fine >> 1)};
  endfunction

endpackage

// File: common/dll_step_if.sv
// per-frame step vectors and search status from the search machine to the tracking blocks
interface dll_step_if;
  import dll_pkg::*;

  dll_step_t up;               // one-hot up step, valid for one cycle
  dll_step_t down;             // one-hot down step, valid for one cycle
  logic      mem_up;           // remembered decision of the frame
  logic      mem_down;
  logic      search_overflow;  // search sum ran past the value range

  modport source (output up, down, mem_up, mem_down, search_overflow);
  modport sink   (input  up, down, mem_up, mem_down, search_overflow);

endinterface

// File: common/dll_strobe_if.sv
// frame strobes from the gate sequencer to the sampler, search and output filter
interface dll_strobe_if;

  logic core_capture;     // latch the synchronized core decision
  logic up_down_capture;  // register the step vectors and decision memory
  logic tog_state;        // advance the search state
  logic pgm_write;        // write the programmed delay
  logic filter_load;      // update the output filter and lock monitor

  modport source (
    output core_capture, up_down_capture, tog_state, pgm_write, filter_load
  );

  modport sink (
    input core_capture, up_down_capture, tog_state, pgm_write, filter_load
  );

endinterface

// File: dv/tb_dll_core.sv
// directed testbench for the dll control core, compiled from filelist.f and run by run_sim.sh
module tb_dll_core;
  import dll_pkg::*;

  localparam int SEED        = 42673;
  localparam int HALF_PERIOD = 50;
  localparam int DRIVE_DELAY = 10;   // inputs move this long after the rising edge
  localparam int STEER_LIMIT = 700;  // frames allowed for a full-range core sweep

  logic        clk;
  logic        reset_n;
  logic        i_ctlsel;
  dll_code_t   i_ctl_static;
  logic        i_core_updnen;
  dll_code_t   i_dly_pst;
  logic        i_core_up;
  logic        i_core_dn;
  logic        i_t_up;
  logic        i_t_down;
  logic        o_up_core;
  logic        o_dn_core;
  logic        o_launch;
  logic        o_measure;
  logic [6:0]  o_f_gray;
  logic [2:0]  o_i_gray;
  logic        o_lock;
  dll_code_t   o_pvt_ref_binary;
  dll_code_t   o_internal_pvt_binary;
  logic        o_search_overflow;
  dll_code_t   o_pvt_ref_gry;
  int          error_count;

  dll_core_top dll_core_top_i (.*);  // port names match one to one

  always #HALF_PERIOD clk = ~clk;

  // ----------------------------------------------------------
  // reference model and reporting
  // ----------------------------------------------------------
  // whole-word gray, then bit 2 restarts the fine group
  function automatic dll_code_t split_gray_ref(input dll_code_t bin);
    dll_code_t g;
    g    = bin ^ {1'b0, bin[9:1]};
    g[2] = bin[2];
    return g;
  endfunction

  task automatic fail_now(input string reason);
    error_count++;
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond) else fail_now($sformatf("ERR @%0t: %s", $time, what));
  endtask

  task automatic expect_code(input string what, input dll_code_t got, input dll_code_t exp);
    assert (got == exp) else
      fail_now($sformatf("ERR @%0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  // mirror checked mid-cycle, then back to the drive point
  task automatic tick();
    @(negedge clk);
    expect_true(o_up_core == i_t_up && o_dn_core == i_t_down,
                "up/down mirror differs from the detector inputs");
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // returns in the first cycle of the next launch pulse
  task automatic next_frame();
    logic last;
    int   cycles;
    last   = o_launch;
    cycles = 0;
    tick();
    while (!(o_launch && !last)) begin
      if (cycles == 2 * DLL_FRAME_CYCLES) fail_now("timeout waiting for the launch pulse");
      cycles++;
      last = o_launch;
      tick();
    end
  endtask

  task automatic apply_reset(input dll_code_t preset);
    i_dly_pst     = preset;
    i_ctlsel      = 1'b0;
    i_ctl_static  = '0;
    i_core_updnen = 1'b0;
    i_core_up     = 1'b0;
    i_core_dn     = 1'b0;
    i_t_up        = 1'b0;
    i_t_down      = 1'b0;
    reset_n       = 1'b0;
    repeat (2) tick();
    reset_n = 1'b1;                    // registers still hold reset values here
  endtask

  // ----------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------
  task automatic reset_values();
    dll_code_t preset;
    preset = 10'($urandom_range(1023));
    apply_reset(preset);
    expect_true(!o_lock && !o_launch && !o_measure, "lock or gate pulse high after reset");
    expect_true(!o_search_overflow, "search overflow high after reset");
    expect_code("reference code after reset", o_pvt_ref_binary, preset);
    expect_code("programmed delay after reset", o_internal_pvt_binary, preset);
    expect_code("gray reference after reset", o_pvt_ref_gry, split_gray_ref(preset));
  endtask

  task automatic frame_pattern();
    int   phase;
    logic exp_launch;
    logic exp_measure;
    apply_reset(10'($urandom_range(1023)));
    next_frame();
    for (int idx = 0; idx < 4 * DLL_FRAME_CYCLES; idx++) begin
      phase       = idx % DLL_FRAME_CYCLES;
      exp_launch  = (phase < 2);                  // two cycles at the frame start
      exp_measure = (phase == 1) || (phase == 2); // same, one cycle later
      expect_true(o_launch == exp_launch,
                  $sformatf("launch is %0b in frame cycle %0d", o_launch, phase));
      expect_true(o_measure == exp_measure,
                  $sformatf("measure is %0b in frame cycle %0d", o_measure, phase));
      tick();
    end
  endtask

  task automatic static_override();
    dll_code_t code;
    int        cycles;
    code = 10'($urandom_range(1023));
    apply_reset(10'($urandom_range(1023)));
    i_ctl_static = code;
    i_ctlsel     = 1'b1;
    cycles       = 0;
    while (o_pvt_ref_binary != code || o_internal_pvt_binary != code) begin
      if (cycles == 2 * DLL_FRAME_CYCLES) fail_now("timeout waiting for the static code");
      cycles++;
      tick();
    end
    expect_code("coarse and fine gray", {o_f_gray, o_i_gray}, split_gray_ref(code));
    i_ctlsel = 1'b0;
  endtask

  task automatic mirror_paths();
    logic [1:0] pick;
    for (int n = 0; n < 24; n++) begin
      pick     = 2'($urandom_range(3));
      i_t_up   = pick[1];
      i_t_down = pick[0];
      tick();
      expect_true(o_up_core == pick[1] && o_dn_core == pick[0], "up/down mirror is wrong");
    end
  endtask

  // strictly rising or falling walk, a stall allowed in the first frame and near the limit
  task automatic steer_to_limit(input logic rising, input dll_code_t limit);
    dll_code_t prev;
    int        frames;
    logic      near_end;
    prev   = o_pvt_ref_binary;
    frames = 0;
    while (prev != limit) begin
      if (frames == STEER_LIMIT) fail_now("timeout waiting for the reference code limit");
      frames++;
      next_frame();
      if (rising) expect_true(o_pvt_ref_binary >= prev, "reference code fell or wrapped");
      else        expect_true(o_pvt_ref_binary <= prev, "reference code rose or wrapped");
      near_end = rising ? (prev >= limit - 10'd2) : (prev <= limit + 10'd2);
      if (o_pvt_ref_binary == prev && frames > 1) begin
        expect_true(near_end, "reference code stopped moving");
      end
      prev = o_pvt_ref_binary;
    end
    repeat (3) begin
      next_frame();
      expect_code("saturated reference code", o_pvt_ref_binary, limit);
    end
  endtask

  task automatic core_steering();
    apply_reset(10'($urandom_range(1023)));
    i_core_updnen = 1'b1;
    i_core_up     = 1'b1;
    steer_to_limit(1'b1, 10'd1023);
    i_core_up = 1'b0;
    i_core_dn = 1'b1;
    steer_to_limit(1'b0, 10'd0);
    i_core_dn     = 1'b0;
    i_core_updnen = 1'b0;
  endtask

  task automatic lock_cycle();
    logic up_phase;
    int   frames;
    apply_reset(10'(256 + $urandom_range(511)));  // away from the value limits
    next_frame();
    up_phase = 1'b1;
    frames   = 0;
    while (!o_lock) begin
      if (frames == 40) fail_now("timeout waiting for lock with alternating decisions");
      frames++;
      i_t_up   = up_phase;
      i_t_down = ~up_phase;
      up_phase = ~up_phase;
      next_frame();
    end
    i_t_up   = 1'b1;                   // a long run climbs the search and breaks lock
    i_t_down = 1'b0;
    frames   = 0;
    while (o_lock) begin
      if (frames == 40) fail_now("lock stayed high while the detector held up");
      frames++;
      next_frame();
    end
  endtask

  initial begin
    void'($urandom(SEED));
    error_count   = 0;
    clk           = 1'b0;
    reset_n       = 1'b0;
    i_ctlsel      = 1'b0;
    i_ctl_static  = '0;
    i_core_updnen = 1'b0;
    i_dly_pst     = '0;
    i_core_up     = 1'b0;
    i_core_dn     = 1'b0;
    i_t_up        = 1'b0;
    i_t_down      = 1'b0;
    reset_values();
    frame_pattern();
    static_override();
    mirror_paths();
    core_steering();
    lock_cycle();
    if (error_count == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

endmodule

// File: filelist.f
common/dll_pkg.sv
common/dll_strobe_if.sv
common/dll_step_if.sv
source/dll_gate_sequencer.sv
source/dll_phase_sampler.sv
search/dll_search_fsm.sv
tracking/dll_tracking_counter.sv
tracking/dll_output_filter.sv
source/dll_core_top.sv
dv/tb_dll_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the dll core testbench with verilator, run it, and look for the pass line in the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_dll_core \
  -Mdir obj_dir -o sim_dll_core

./obj_dir/sim_dll_core | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: search/dll_search_fsm.sv
// binary search: run counter and state machine, search offset, programmed delay and step vectors
module dll_search_fsm (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                i_core_updnen,
  input  logic                i_ctlsel,          // static override
  input  dll_pkg::dll_code_t  i_ctl_static,
  input  dll_pkg::dll_code_t  i_dly_pst,         // reset preset
  input  logic                i_new_up,          // decision of this frame
  input  logic                i_new_dn,
  input  logic                i_mem_up,          // remembered decision
  input  logic                i_mem_dn,
  input  dll_pkg::dll_value_t i_internal_value,
  dll_strobe_if.sink          strobe,
  dll_step_if.source          step,
  output dll_pkg::dll_code_t  o_internal_pvt_binary,
  output logic [6:0]          o_f_gray,          // coarse gray for the nand chain
  output logic [2:0]          o_i_gray,          // fine gray for the interpolator
  output logic                o_search_overflow,
  output logic                o_state_level      // search above level 0
);
  import dll_pkg::*;

  dll_state_e  state;
  logic [4:0]  run_cnt;       // consecutive decisions in the search direction
  logic        dir;           // 1 = searching down
  logic [2:0]  level;         // 0..4
  logic        fwd;           // decision agrees with the direction
  logic        rev;           // decision opposes it
  logic        run_done;      // run long enough to climb a level
  logic [13:0] offset_mag;
  logic [13:0] search_value;  // internal value plus signed offset, bit 13 flags overflow
  dll_code_t   int_pvt_value;
  dll_step_t   step_mask;
  dll_code_t   pvt_gray;

  function automatic dll_state_e state_at(input logic d, input logic [2:0] lvl);
    logic [1:0] sub;
    sub = 2'(lvl - 3'd1);
    if (lvl == 3'd0) return dll_state_e'({d, 3'b000});
    return dll_state_e'({d, 1'b1, sub});
  endfunction

  assign dir   = state[3];
  assign level = state[2] ? 3'(state[1:0]) + 3'd1 : 3'd0;
  assign fwd   = dir ? i_mem_dn : i_mem_up;
  assign rev   = dir ? i_mem_up : i_mem_dn;

  always_comb begin
    case (level)
      3'd0:    run_done = &run_cnt;       // 32 in a row
      3'd1:    run_done = &run_cnt[3:0];  // 16
      3'd2:    run_done = &run_cnt[2:0];  // 8
      3'd3:    run_done = &run_cnt[1:0];  // 4
      default: run_done = 1'b0;           // top level
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      run_cnt <= '0;
    end else if (strobe.tog_state) begin
      if (fwd & ~rev)      run_cnt <= run_cnt + 5'd1;
      else if (rev & ~fwd) run_cnt <= '0;  // reversal restarts the run
    end
  end

  // ----------------------------------------------------------
  // search state, steps at tog_state
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= UP_S0;
    end else if (strobe.tog_state) begin
      if (i_core_updnen) begin
        state <= i_mem_up ? UP_S1 : i_mem_dn ? DN_S1 : state_at(dir, 3'd0);
      end else if (i_internal_value[12:5] == 8'h00 && dir) begin
        state <= UP_S0;                    // at the bottom, turn up
      end else if (i_internal_value[12:5] == 8'hFF && !dir) begin
        state <= DN_S0;                    // at the top, turn down
      end else if (fwd & run_done) begin
        state <= state_at(dir, level + 3'd1);
      end else if (fwd & ~rev) begin
        state <= state;
      end else if (level == 3'd0) begin
        state <= state_at(~dir, 3'd0);     // flip direction
      end else begin
        state <= state_at(dir, level - 3'd1);
      end
    end
  end

  // offset of 16 internal units at level 1, doubling per level
  assign offset_mag    = (level == 3'd0) ? 14'd0 : 14'd16 << (level - 3'd1);
  assign search_value  = {1'b0, i_internal_value} + (dir ? -offset_mag : offset_mag);
  assign int_pvt_value = search_value[13] ? i_internal_value[12:3] : search_value[12:3];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      o_internal_pvt_binary <= i_dly_pst;
      o_search_overflow     <= 1'b0;
    end else begin
      if (i_ctlsel)              o_internal_pvt_binary <= i_ctl_static;
      else if (strobe.pgm_write) o_internal_pvt_binary <= int_pvt_value;
      if (strobe.pgm_write) o_search_overflow <= search_value[13];
    end
  end

  // ----------------------------------------------------------
  // step vectors, one cycle after up_down_capture
  // ----------------------------------------------------------
  assign step_mask = i_core_updnen ? 5'b00010 : 5'b00001 << level;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      step.up   <= '0;
      step.down <= '0;
    end else if (!strobe.up_down_capture || o_search_overflow) begin
      step.up   <= '0;
      step.down <= '0;
    end else begin
      // above level 0 only the search direction moves
      step.up   <= (i_core_updnen | ~dir | ~state[2]) ? step_mask & {5{i_new_up}} : '0;
      step.down <= (i_core_updnen | dir | ~state[2]) ? step_mask & {5{i_new_dn}} : '0;
    end
  end

  assign step.mem_up          = i_mem_up;
  assign step.mem_down        = i_mem_dn;
  assign step.search_overflow = o_search_overflow;
  assign o_state_level        = state[2];

  assign pvt_gray = to_split_gray(o_internal_pvt_binary);
  assign o_f_gray = pvt_gray[9:3];
  assign o_i_gray = pvt_gray[2:0];

endmodule

// File: source/dll_core_top.sv
// dll control core top level: wires the sequencer, sampler, search and tracking blocks
module dll_core_top (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               i_ctlsel,               // static override select
  input  dll_pkg::dll_code_t i_ctl_static,
  input  logic               i_core_updnen,          // steer from the core
  input  dll_pkg::dll_code_t i_dly_pst,              // reset preset
  input  logic               i_core_up,
  input  logic               i_core_dn,
  input  logic               i_t_up,                 // phase detector
  input  logic               i_t_down,
  output logic               o_up_core,              // detector mirror to the core
  output logic               o_dn_core,
  output logic               o_launch,
  output logic               o_measure,
  output logic [6:0]         o_f_gray,
  output logic [2:0]         o_i_gray,
  output logic               o_lock,
  output dll_pkg::dll_code_t o_pvt_ref_binary,
  output dll_pkg::dll_code_t o_internal_pvt_binary,
  output logic               o_search_overflow,
  output dll_pkg::dll_code_t o_pvt_ref_gry
);
  import dll_pkg::*;

  dll_strobe_if strobe_bus ();
  dll_step_if   step_bus ();

  logic        new_up;
  logic        new_dn;
  logic        mem_up;
  logic        mem_dn;
  logic        state_level;
  dll_value_t  internal_value;
  logic [15:0] tcalc_up;
  logic [15:0] tcalc_down;

  assign o_up_core = i_t_up;
  assign o_dn_core = i_t_down;

  dll_gate_sequencer dll_gate_sequencer_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .o_launch  (o_launch),
    .o_measure (o_measure),
    .strobe    (strobe_bus.source)
  );

  dll_phase_sampler dll_phase_sampler_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_core_up     (i_core_up),
    .i_core_dn     (i_core_dn),
    .i_t_up        (i_t_up),
    .i_t_down      (i_t_down),
    .i_core_updnen (i_core_updnen),
    .i_overflow    (o_search_overflow),
    .strobe        (strobe_bus.sink),
    .o_new_up      (new_up),
    .o_new_dn      (new_dn),
    .o_mem_up      (mem_up),
    .o_mem_dn      (mem_dn)
  );

  dll_search_fsm dll_search_fsm_i (
    .clk                   (clk),
    .reset_n               (reset_n),
    .i_core_updnen         (i_core_updnen),
    .i_ctlsel              (i_ctlsel),
    .i_ctl_static          (i_ctl_static),
    .i_dly_pst             (i_dly_pst),
    .i_new_up              (new_up),
    .i_new_dn              (new_dn),
    .i_mem_up              (mem_up),
    .i_mem_dn              (mem_dn),
    .i_internal_value      (internal_value),
    .strobe                (strobe_bus.sink),
    .step                  (step_bus.source),
    .o_internal_pvt_binary (o_internal_pvt_binary),
    .o_f_gray              (o_f_gray),
    .o_i_gray              (o_i_gray),
    .o_search_overflow     (o_search_overflow),
    .o_state_level         (state_level)
  );

  dll_tracking_counter dll_tracking_counter_i (
    .clk              (clk),
    .reset_n          (reset_n),
    .i_dly_pst        (i_dly_pst),
    .step             (step_bus.sink),
    .o_internal_value (internal_value),
    .o_tcalc_up       (tcalc_up),
    .o_tcalc_down     (tcalc_down)
  );

  dll_output_filter dll_output_filter_i (
    .clk              (clk),
    .reset_n          (reset_n),
    .i_ctlsel         (i_ctlsel),
    .i_ctl_static     (i_ctl_static),
    .i_dly_pst        (i_dly_pst),
    .i_internal_value (internal_value),
    .i_tcalc_up       (tcalc_up),
    .i_tcalc_down     (tcalc_down),
    .i_state_level    (state_level),
    .strobe           (strobe_bus.sink),
    .step             (step_bus.sink),
    .o_pvt_ref_binary (o_pvt_ref_binary),
    .o_pvt_ref_gry    (o_pvt_ref_gry),
    .o_lock           (o_lock)
  );

endmodule

// File: source/dll_gate_sequencer.sv
// gate sequencer: frame counter and gate shift register, decoded into pulses and strobes
module dll_gate_sequencer (
  input  logic         clk,
  input  logic         reset_n,
  output logic         o_launch,   // into the analog delay line
  output logic         o_measure,  // phase detector clock
  dll_strobe_if.source strobe
);
  import dll_pkg::*;

  localparam logic [3:0] FRAME_LAST = 4'(DLL_FRAME_CYCLES - 1);

  logic [3:0] frame_cnt;  // position in the frame
  logic [6:0] gate_shf;   // each bit trails the one below by a cycle

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      frame_cnt <= '0;
    end else if (frame_cnt == FRAME_LAST) begin
      frame_cnt <= '0;                   // wrap at the frame end
    end else begin
      frame_cnt <= frame_cnt + 4'd1;
    end
  end

  // bit 0 is set for the first two counts of the frame
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      gate_shf <= '0;
    end else begin
      gate_shf <= {gate_shf[5:0], frame_cnt[3:1] == 3'b000};
    end
  end

  // ----------------------------------------------------------
  // decodes, each strobe is one cycle per frame
  // ----------------------------------------------------------
  assign o_launch  = gate_shf[0];
  assign o_measure = gate_shf[1];                             // launch plus one

  assign strobe.core_capture    = (gate_shf[3:2] == 2'b11);
  assign strobe.up_down_capture = (gate_shf[5:4] == 2'b01);   // next cycle
  assign strobe.tog_state       = (gate_shf[5:4] == 2'b11);
  assign strobe.pgm_write       = (gate_shf[5:4] == 2'b10);
  assign strobe.filter_load     = (gate_shf[6:5] == 2'b10);   // last of the frame

endmodule

// File: source/dll_phase_sampler.sv
// decision sampler: core up/down sync and capture, source select and the decision memory
module dll_phase_sampler (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       i_core_up,      // asynchronous, from the core
  input  logic       i_core_dn,
  input  logic       i_t_up,         // phase detector outputs
  input  logic       i_t_down,
  input  logic       i_core_updnen,  // steer from the core instead of the detector
  input  logic       i_overflow,     // search overflow clears the memory
  dll_strobe_if.sink strobe,
  output logic       o_new_up,
  output logic       o_new_dn,
  output logic       o_mem_up,
  output logic       o_mem_dn
);

  logic [1:0] sync_meta;  // {up, dn} first stage
  logic [1:0] sync_q;     // second stage
  logic [1:0] core_cap;   // held from core_capture on
  logic       sel_up;
  logic       sel_dn;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      sync_meta <= '0;
      sync_q    <= '0;
      core_cap  <= '0;
    end else begin
      sync_meta <= {i_core_up, i_core_dn};
      sync_q    <= sync_meta;
      if (strobe.core_capture) core_cap <= sync_q;
    end
  end

  assign sel_up = i_core_updnen ? core_cap[1] : i_t_up;
  assign sel_dn = i_core_updnen ? core_cap[0] : i_t_down;

  // up together with down cancels
  assign o_new_up = sel_up & ~sel_dn;
  assign o_new_dn = sel_dn & ~sel_up;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      o_mem_up <= 1'b0;
      o_mem_dn <= 1'b0;
    end else if (i_overflow) begin
      o_mem_up <= 1'b0;                  // forget while the search is out of range
      o_mem_dn <= 1'b0;
    end else if (strobe.up_down_capture) begin
      o_mem_up <= o_new_up;
      o_mem_dn <= o_new_dn;
    end
  end

endmodule

// File: tracking/dll_output_filter.sv
// output filter with hysteresis, lock monitor and the registered gray reference code
module dll_output_filter (
  input  logic                                 clk,
  input  logic                                 reset_n,
  input  logic                                 i_ctlsel,
  input  dll_pkg::dll_code_t                   i_ctl_static,
  input  dll_pkg::dll_code_t                   i_dly_pst,
  input  dll_pkg::dll_value_t                  i_internal_value,
  input  logic [$bits(dll_pkg::dll_track_t):0] i_tcalc_up,
  input  logic [$bits(dll_pkg::dll_track_t):0] i_tcalc_down,
  input  logic                                 i_state_level,  // search above level 0
  dll_strobe_if.sink                           strobe,
  dll_step_if.sink                             step,
  output dll_pkg::dll_code_t                   o_pvt_ref_binary,
  output dll_pkg::dll_code_t                   o_pvt_ref_gry,
  output logic                                 o_lock
);
  import dll_pkg::*;

  localparam logic [20:0] FILT_TOP = 21'h1FFF80;  // saturated value, hysteresis mid

  logic [20:0] filt;       // {filtered value, 8 bit hysteresis}
  dll_value_t  pvt_value;
  logic        hyst_hi;
  logic [20:0] dither;     // small with lock, larger without
  dll_value_t  diff;
  logic        large_up;
  logic        large_down;
  logic        lock_det;
  logic [3:0]  lock_cnt;

  assign pvt_value  = filt[20:8];
  assign hyst_hi    = filt[7];
  assign dither     = 21'({~o_lock, 3'h4});
  assign large_up   = |step.up[4:1];
  assign large_down = |step.down[4:1];

  // ----------------------------------------------------------
  // filtered value
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      filt <= {i_dly_pst, 11'h000};
    end else if (i_ctlsel) begin
      filt <= {i_ctl_static, 11'h000};
    end else if (large_up) begin
      filt <= i_tcalc_up[15] ? FILT_TOP : {i_tcalc_up[14:2], 8'h80};  // jump with the search
    end else if (large_down) begin
      filt <= i_tcalc_down[15] ? '0 : {i_tcalc_down[14:2], 8'h80};
    end else if (strobe.filter_load) begin
      if (i_internal_value == pvt_value) begin
        filt <= hyst_hi ? filt - dither : filt + dither;  // dither across the midpoint
      end else if (o_lock) begin
        filt <= filt + 21'(i_internal_value) - 21'(pvt_value);  // 1/256 of the gap
      end else begin
        filt <= filt + 21'({i_internal_value, 6'h00}) - 21'({pvt_value, 6'h00});  // 1/4
      end
    end
  end

  // ----------------------------------------------------------
  // lock monitor
  // ----------------------------------------------------------
  assign diff = i_internal_value - pvt_value;
  // close enough, and the frame carried a decision
  assign lock_det = strobe.filter_load & (diff[12:2] == 11'h000) & (step.mem_up | step.mem_down);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      lock_cnt <= '0;
    end else if (i_state_level || step.search_overflow) begin
      lock_cnt <= '0;                          // large search activity drops lock
    end else if (lock_cnt != 4'(LOCK_COUNT_TARGET)) begin
      lock_cnt <= lock_cnt + 4'(lock_det);
    end
  end

  assign o_lock           = (lock_cnt == 4'(LOCK_COUNT_TARGET));
  assign o_pvt_ref_binary = pvt_value[12:3];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      o_pvt_ref_gry <= to_split_gray(i_dly_pst);
    end else begin
      o_pvt_ref_gry <= to_split_gray(o_pvt_ref_binary);  // one cycle behind the binary
    end
  end

endmodule

// File: tracking/dll_tracking_counter.sv
// internal delay tracking: saturating up/down counter with its 2 bit filter
module dll_tracking_counter (
  input  logic                                  clk,
  input  logic                                  reset_n,
  input  dll_pkg::dll_code_t                    i_dly_pst,
  dll_step_if.sink                              step,
  output dll_pkg::dll_value_t                   o_internal_value,
  output logic [$bits(dll_pkg::dll_track_t):0]  o_tcalc_up,    // with carry
  output logic [$bits(dll_pkg::dll_track_t):0]  o_tcalc_down   // with borrow
);
  import dll_pkg::*;

  dll_track_t track;      // {internal value, filter}
  dll_track_t up_amt;
  dll_track_t down_amt;
  logic       any_up;
  logic       any_down;

  // bit 0 moves one filter lsb, bit k moves 64 << (k-1)
  assign up_amt   = dll_track_t'({step.up[4:1], 5'b00000, step.up[0]});
  assign down_amt = dll_track_t'({step.down[4:1], 5'b00000, step.down[0]});

  assign o_tcalc_up   = {1'b0, track} + {1'b0, up_amt};
  assign o_tcalc_down = {1'b0, track} - {1'b0, down_amt};

  assign any_up   = |step.up;
  assign any_down = |step.down;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      track <= {i_dly_pst, 5'b00000};
    end else if (any_up) begin
      track <= o_tcalc_up[15] ? '1 : o_tcalc_up[14:0];      // clamp at all ones
    end else if (any_down) begin
      track <= o_tcalc_down[15] ? '0 : o_tcalc_down[14:0];  // clamp at zero
    end
  end

  assign o_internal_value = track[14:2];

endmodule
